// File: filelist.f
hdl/dispatch_pkg.sv
hdl/map_table.sv
hdl/reorder_buffer.sv
hdl/arch_regfile.sv
hdl/dispatcher.sv
hdl/dispatch_core.sv
tests/dispatch_tb.sv

// File: hdl/arch_regfile.sv
`default_nettype none

module arch_regfile import dispatch_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      we,
    input  wire reg_addr_t waddr,
    input  wire word_t     wdata,
    input  wire reg_addr_t raddr1,
    input  wire reg_addr_t raddr2,
    output word_t          rdata1,
    output word_t          rdata2
);

    word_t regs [REG_NUM];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // no bypass, the committing value is still in the rob
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: hdl/dispatch_core.sv
`default_nettype none

module dispatch_core import dispatch_pkg::*; (
    input  wire logic              clk,
    input  wire logic              reset,

    input  wire logic              inst_valid,
    input  wire fu_t               inst_fu,
    input  wire func_t             inst_func,
    input  wire reg_addr_t         inst_dest,
    input  wire reg_addr_t         inst_src1,
    input  wire reg_addr_t         inst_src2,
    input  wire word_t             inst_imm,
    input  wire logic              inst_imm_valid,
    input  wire word_t             inst_pc,
    input  wire logic              inst_pc_valid,
    output logic                   stall,

    input  wire logic [RS_NUM-1:0] rs_full,
    output logic [RS_NUM-1:0]      rs_load,
    output func_t                  rs_func,
    output rob_tag_t               rs_tag_dest,
    output rob_tag_t               rs_tag_src1,
    output rob_tag_t               rs_tag_src2,
    output logic                   rs_ready_src1,
    output logic                   rs_ready_src2,
    output word_t                  rs_value_src1,
    output word_t                  rs_value_src2,
    output word_t                  rs_imm,
    output word_t                  rs_pc,

    input  wire logic              cdb_valid,
    input  wire rob_tag_t          cdb_tag,
    input  wire word_t             cdb_data,

    output logic                   commit_valid,
    output rob_tag_t               commit_tag,
    output reg_addr_t              commit_reg,
    output word_t                  commit_data,
    output word_t                  commit_npc
);

    // dispatcher to rob
    logic      alloc;
    reg_addr_t alloc_reg;
    word_t     alloc_npc;
    rob_tag_t  tail_tag;
    logic      rob_full;
    rob_tag_t  rob_src1_tag;
    rob_tag_t  rob_src2_tag;
    logic      src1_done;
    logic      src2_done;
    word_t     src1_data;
    word_t     src2_data;

    // dispatcher to register file
    reg_addr_t reg_raddr1;
    reg_addr_t reg_raddr2;
    word_t     reg_rdata1;
    word_t     reg_rdata2;

    dispatcher disp0 (
        .clk            (clk),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .inst_fu        (inst_fu),
        .inst_func      (inst_func),
        .inst_dest      (inst_dest),
        .inst_src1      (inst_src1),
        .inst_src2      (inst_src2),
        .inst_imm       (inst_imm),
        .inst_imm_valid (inst_imm_valid),
        .inst_pc        (inst_pc),
        .inst_pc_valid  (inst_pc_valid),
        .rs_full        (rs_full),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data),
        .tail_tag       (tail_tag),
        .rob_full       (rob_full),
        .src1_done      (src1_done),
        .src1_data      (src1_data),
        .src2_done      (src2_done),
        .src2_data      (src2_data),
        .commit_valid   (commit_valid),
        .commit_tag     (commit_tag),
        .commit_reg     (commit_reg),
        .rob_src1_tag   (rob_src1_tag),
        .rob_src2_tag   (rob_src2_tag),
        .alloc          (alloc),
        .alloc_reg      (alloc_reg),
        .alloc_npc      (alloc_npc),
        .reg_rdata1     (reg_rdata1),
        .reg_rdata2     (reg_rdata2),
        .reg_raddr1     (reg_raddr1),
        .reg_raddr2     (reg_raddr2),
        .stall          (stall),
        .rs_load        (rs_load),
        .rs_func        (rs_func),
        .rs_tag_dest    (rs_tag_dest),
        .rs_tag_src1    (rs_tag_src1),
        .rs_tag_src2    (rs_tag_src2),
        .rs_ready_src1  (rs_ready_src1),
        .rs_ready_src2  (rs_ready_src2),
        .rs_value_src1  (rs_value_src1),
        .rs_value_src2  (rs_value_src2),
        .rs_imm         (rs_imm),
        .rs_pc          (rs_pc)
    );

    reorder_buffer rob0 (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc),
        .alloc_reg    (alloc_reg),
        .alloc_npc    (alloc_npc),
        .tail_tag     (tail_tag),
        .rob_full     (rob_full),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_data     (cdb_data),
        .src1_tag     (rob_src1_tag),
        .src2_tag     (rob_src2_tag),
        .src1_done    (src1_done),
        .src1_data    (src1_data),
        .src2_done    (src2_done),
        .src2_data    (src2_data),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .commit_reg   (commit_reg),
        .commit_data  (commit_data),
        .commit_npc   (commit_npc)
    );

    // x0 writes are dropped inside the register file
    arch_regfile rf0 (
        .clk    (clk),
        .reset  (reset),
        .we     (commit_valid),
        .waddr  (commit_reg),
        .wdata  (commit_data),
        .raddr1 (reg_raddr1),
        .raddr2 (reg_raddr2),
        .rdata1 (reg_rdata1),
        .rdata2 (reg_rdata2)
    );

endmodule

`default_nettype wire

// File: hdl/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

    // datapath width
    localparam int XLEN = 32;

    // architectural register file
    localparam int REG_NUM      = 32;
    localparam int REG_ADDR_LEN = 5;

    // reorder buffer, power of two so the pointers wrap on their own
    localparam int ROB_SIZE    = 8;
    localparam int ROB_TAG_LEN = 3;

    // one station per functional unit
    localparam int RS_NUM = 4;

    // operation code handed to the unit
    localparam int FUNC_LEN = 4;

    // data, pc and immediate values
    typedef logic [XLEN-1:0] word_t;

    // architectural register index
    typedef logic [REG_ADDR_LEN-1:0] reg_addr_t;

    // rob entry index, also the rename tag
    typedef logic [ROB_TAG_LEN-1:0] rob_tag_t;

    // unit operation code
    typedef logic [FUNC_LEN-1:0] func_t;

    // unit select, doubles as the index into rs_full and rs_load
    typedef enum logic [1:0] {
        FU_ALU  = 2'd0,
        FU_MULT = 2'd1,
        FU_BTU  = 2'd2,
        FU_LSU  = 2'd3
    } fu_t;

endpackage

`default_nettype wire

// File: hdl/dispatcher.sv
`default_nettype none

module dispatcher import dispatch_pkg::*; (
    input  wire logic              clk,
    input  wire logic              reset,

    // decoded instruction
    input  wire logic              inst_valid,
    input  wire fu_t               inst_fu,
    input  wire func_t             inst_func,
    input  wire reg_addr_t         inst_dest,
    input  wire reg_addr_t         inst_src1,
    input  wire reg_addr_t         inst_src2,
    input  wire word_t             inst_imm,
    input  wire logic              inst_imm_valid,
    input  wire word_t             inst_pc,
    input  wire logic              inst_pc_valid,

    input  wire logic [RS_NUM-1:0] rs_full,

    input  wire logic              cdb_valid,
    input  wire rob_tag_t          cdb_tag,
    input  wire word_t             cdb_data,

    // rob side
    input  wire rob_tag_t          tail_tag,
    input  wire logic              rob_full,
    input  wire logic              src1_done,
    input  wire word_t             src1_data,
    input  wire logic              src2_done,
    input  wire word_t             src2_data,
    input  wire logic              commit_valid,
    input  wire rob_tag_t          commit_tag,
    input  wire reg_addr_t         commit_reg,
    output rob_tag_t               rob_src1_tag,
    output rob_tag_t               rob_src2_tag,
    output logic                   alloc,
    output reg_addr_t              alloc_reg,
    output word_t                  alloc_npc,

    // register file side
    input  wire word_t             reg_rdata1,
    input  wire word_t             reg_rdata2,
    output reg_addr_t              reg_raddr1,
    output reg_addr_t              reg_raddr2,

    // reservation stations
    output logic                   stall,
    output logic [RS_NUM-1:0]      rs_load,
    output func_t                  rs_func,
    output rob_tag_t               rs_tag_dest,
    output rob_tag_t               rs_tag_src1,
    output rob_tag_t               rs_tag_src2,
    output logic                   rs_ready_src1,
    output logic                   rs_ready_src2,
    output word_t                  rs_value_src1,
    output word_t                  rs_value_src2,
    output word_t                  rs_imm,
    output word_t                  rs_pc
);

    // held instruction
    logic      valid_r;
    fu_t       fu_r;
    func_t     func_r;
    reg_addr_t dest_r;
    reg_addr_t src1_r;
    reg_addr_t src2_r;
    word_t     imm_r;
    logic      imm_valid_r;
    word_t     pc_r;
    logic      pc_valid_r;

    logic      map1_busy;
    logic      map2_busy;
    rob_tag_t  map1_tag;
    rob_tag_t  map2_tag;
    logic      is_btu;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else if (!stall) begin
            valid_r <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            fu_r        <= inst_fu;
            func_r      <= inst_func;
            dest_r      <= inst_dest;
            src1_r      <= inst_src1;
            src2_r      <= inst_src2;
            imm_r       <= inst_imm;
            imm_valid_r <= inst_imm_valid;
            pc_r        <= inst_pc;
            pc_valid_r  <= inst_pc_valid;
        end
    end

    map_table mt0 (
        .clk       (clk),
        .reset     (reset),
        .set       (alloc),
        .set_reg   (dest_r),
        .set_tag   (tail_tag),
        .clear     (commit_valid),
        .clear_reg (commit_reg),
        .clear_tag (commit_tag),
        .src1      (src1_r),
        .src2      (src2_r),
        .src1_busy (map1_busy),
        .src2_busy (map2_busy),
        .src1_tag  (map1_tag),
        .src2_tag  (map2_tag)
    );

    assign is_btu = (fu_r == FU_BTU);

    // operand sources, in order of precedence
    function automatic void pick_operand(
        input  logic     sub,
        input  word_t    sub_val,
        input  logic     busy,
        input  rob_tag_t tag,
        input  word_t    reg_val,
        input  logic     rob_done,
        input  word_t    rob_val,
        input  logic     bus_valid,
        input  rob_tag_t bus_tag,
        input  word_t    bus_data,
        output logic     ready,
        output word_t    value,
        output rob_tag_t tag_out
    );
        ready   = 1'b1;
        value   = '0;
        tag_out = '0;
        if (sub) begin
            value = sub_val;
        end else if (!busy) begin
            value = reg_val;
        end else begin
            tag_out = tag;
            if (rob_done) begin
                value = rob_val;
            end else if (bus_valid && (bus_tag == tag)) begin
                // result arrives on the cdb this very cycle
                value = bus_data;
            end else begin
                ready = 1'b0;
            end
        end
    endfunction

    always_comb begin
        pick_operand(pc_valid_r && !is_btu, pc_r, map1_busy, map1_tag, reg_rdata1,
                     src1_done, src1_data, cdb_valid, cdb_tag, cdb_data,
                     rs_ready_src1, rs_value_src1, rs_tag_src1);
        pick_operand(imm_valid_r && !is_btu, imm_r, map2_busy, map2_tag, reg_rdata2,
                     src2_done, src2_data, cdb_valid, cdb_tag, cdb_data,
                     rs_ready_src2, rs_value_src2, rs_tag_src2);
    end

    assign reg_raddr1   = src1_r;
    assign reg_raddr2   = src2_r;
    assign rob_src1_tag = map1_tag;
    assign rob_src2_tag = map2_tag;

    // hold while the target station or the rob has no room
    assign stall = valid_r && (rs_full[fu_r] || rob_full);
    assign alloc = valid_r && !stall;

    always_comb begin
        rs_load = '0;
        if (alloc) begin
            rs_load[fu_r] = 1'b1;
        end
    end

    assign alloc_reg = dest_r;
    assign alloc_npc = pc_r + 32'd4;

    assign rs_func     = func_r;
    assign rs_tag_dest = tail_tag;
    assign rs_imm      = is_btu ? imm_r : '0;
    assign rs_pc       = is_btu ? pc_r : '0;

endmodule

`default_nettype wire

// File: hdl/map_table.sv
`default_nettype none

module map_table import dispatch_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,

    // rename on dispatch
    input  wire logic      set,
    input  wire reg_addr_t set_reg,
    input  wire rob_tag_t  set_tag,

    // release on commit
    input  wire logic      clear,
    input  wire reg_addr_t clear_reg,
    input  wire rob_tag_t  clear_tag,

    // source lookups
    input  wire reg_addr_t src1,
    input  wire reg_addr_t src2,
    output logic           src1_busy,
    output logic           src2_busy,
    output rob_tag_t       src1_tag,
    output rob_tag_t       src2_tag
);

    logic     map_valid [REG_NUM];
    rob_tag_t map_tag   [REG_NUM];

    logic set_en;
    logic clear_en;

    // x0 is never renamed
    assign set_en = set && (set_reg != '0);

    // only drop the mapping if no younger writer took the register over
    assign clear_en = clear && (clear_reg != '0) && map_valid[clear_reg] &&
                      (map_tag[clear_reg] == clear_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_NUM; i++) begin
                map_valid[i] <= 1'b0;
            end
        end else begin
            if (clear_en) begin
                map_valid[clear_reg] <= 1'b0;
            end
            // set comes last so it wins on the same register
            if (set_en) begin
                map_valid[set_reg] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (set_en) begin
            map_tag[set_reg] <= set_tag;
        end
    end

    assign src1_busy = map_valid[src1];
    assign src2_busy = map_valid[src2];
    assign src1_tag  = map_tag[src1];
    assign src2_tag  = map_tag[src2];

endmodule

`default_nettype wire

// File: hdl/reorder_buffer.sv
`default_nettype none

module reorder_buffer import dispatch_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,

    // allocation from the dispatcher
    input  wire logic      alloc,
    input  wire reg_addr_t alloc_reg,
    input  wire word_t     alloc_npc,
    output rob_tag_t       tail_tag,
    output logic           rob_full,

    // writeback
    input  wire logic      cdb_valid,
    input  wire rob_tag_t  cdb_tag,
    input  wire word_t     cdb_data,

    // operand reads
    input  wire rob_tag_t  src1_tag,
    input  wire rob_tag_t  src2_tag,
    output logic           src1_done,
    output word_t          src1_data,
    output logic           src2_done,
    output word_t          src2_data,

    // retirement
    output logic           commit_valid,
    output rob_tag_t       commit_tag,
    output reg_addr_t      commit_reg,
    output word_t          commit_data,
    output word_t          commit_npc
);

    logic      entry_busy  [ROB_SIZE];
    logic      entry_done  [ROB_SIZE];
    reg_addr_t entry_dest  [ROB_SIZE];
    word_t     entry_value [ROB_SIZE];
    word_t     entry_npc   [ROB_SIZE];

    rob_tag_t               head;
    rob_tag_t               tail;
    logic [ROB_TAG_LEN:0]   count;

    // head retires as soon as its result is in
    assign commit_valid = entry_busy[head] && entry_done[head];
    assign commit_tag   = head;
    assign commit_reg   = entry_dest[head];
    assign commit_data  = entry_value[head];
    assign commit_npc   = entry_npc[head];

    assign tail_tag = tail;

    // count only, a retiring head does not free a slot this cycle
    assign rob_full = (count == (ROB_TAG_LEN + 1)'(ROB_SIZE));

    assign src1_done = entry_busy[src1_tag] && entry_done[src1_tag];
    assign src1_data = entry_value[src1_tag];
    assign src2_done = entry_busy[src2_tag] && entry_done[src2_tag];
    assign src2_data = entry_value[src2_tag];

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < ROB_SIZE; i++) begin
                entry_busy[i] <= 1'b0;
                entry_done[i] <= 1'b0;
            end
        end else begin
            if (commit_valid) begin
                entry_busy[head] <= 1'b0;
                entry_done[head] <= 1'b0;
                head             <= head + 1'b1;
            end
            if (alloc) begin
                entry_busy[tail] <= 1'b1;
                entry_done[tail] <= 1'b0;
                tail             <= tail + 1'b1;
            end
            // only outstanding entries get broadcast
            if (cdb_valid) begin
                entry_done[cdb_tag] <= 1'b1;
            end
            case ({alloc, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            entry_dest[tail] <= alloc_reg;
            entry_npc[tail]  <= alloc_npc;
        end
        if (cdb_valid) begin
            entry_value[cdb_tag] <= cdb_data;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the dispatch testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module dispatch_tb \
    -f filelist.f -o dispatch_sim \
    || { echo "verilator build error"; exit 1; }

./obj_dir/dispatch_sim > sim.log 2>&1
cat sim.log

# the log decides the result
! grep -q "tests failed" sim.log && grep -q "all tests passed" sim.log \
    && exit 0 || exit 1

// File: tests/dispatch_tb.sv
`default_nettype none

module dispatch_tb import dispatch_pkg::*; ;

    localparam int CLK_PERIOD    = 8;
    localparam int NUM_INST      = 400;
    localparam int WATCHDOG_TIME = NUM_INST * 20 * CLK_PERIOD;

    logic              clk = 1'b0;
    logic              reset;
    logic              inst_valid;
    fu_t               inst_fu;
    func_t             inst_func;
    reg_addr_t         inst_dest;
    reg_addr_t         inst_src1;
    reg_addr_t         inst_src2;
    word_t             inst_imm;
    logic              inst_imm_valid;
    word_t             inst_pc;
    logic              inst_pc_valid;
    logic [RS_NUM-1:0] rs_full;
    logic              cdb_valid;
    rob_tag_t          cdb_tag;
    word_t             cdb_data;

    logic              stall;
    logic [RS_NUM-1:0] rs_load;
    func_t             rs_func;
    rob_tag_t          rs_tag_dest;
    rob_tag_t          rs_tag_src1;
    rob_tag_t          rs_tag_src2;
    logic              rs_ready_src1;
    logic              rs_ready_src2;
    word_t             rs_value_src1;
    word_t             rs_value_src2;
    word_t             rs_imm;
    word_t             rs_pc;
    logic              commit_valid;
    rob_tag_t          commit_tag;
    reg_addr_t         commit_reg;
    word_t             commit_data;
    word_t             commit_npc;

    // reference model state
    logic      ref_map_valid [REG_NUM];
    rob_tag_t  ref_map_tag   [REG_NUM];
    word_t     ref_regs      [REG_NUM];
    logic      ref_busy      [ROB_SIZE];
    logic      ref_done      [ROB_SIZE];
    reg_addr_t ref_dest      [ROB_SIZE];
    word_t     ref_value     [ROB_SIZE];
    word_t     ref_npc       [ROB_SIZE];
    rob_tag_t  ref_head;
    rob_tag_t  ref_tail;
    int        ref_count;

    // model copy of the held instruction
    logic      held_valid;
    fu_t       held_fu;
    func_t     held_func;
    reg_addr_t held_dest;
    reg_addr_t held_src1;
    reg_addr_t held_src2;
    word_t     held_imm;
    logic      held_imm_valid;
    word_t     held_pc;
    logic      held_pc_valid;

    logic              exp_stall;
    logic              exp_alloc;
    logic              exp_commit;
    logic [RS_NUM-1:0] exp_load;

    int n_dispatched = 0;
    int n_stalls = 0;
    int n_commits = 0;
    int n_kept_renames = 0;

    dispatch_core dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else stop_with_error($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
    endtask

    // expected operand by precedence of substitution, register file, done rob entry and cdb
    task automatic expect_operand(input logic sub, input word_t sub_val, input reg_addr_t src,
                                  output logic ready, output word_t value,
                                  output rob_tag_t tag);
        ready = 1'b1;
        value = '0;
        tag   = '0;
        if (sub) begin
            value = sub_val;
        end else if (!ref_map_valid[src]) begin
            value = ref_regs[src];
        end else begin
            tag = ref_map_tag[src];
            if (ref_busy[tag] && ref_done[tag]) begin
                value = ref_value[tag];
            end else if (cdb_valid && cdb_tag == tag) begin
                value = cdb_data;
            end else begin
                ready = 1'b0;
            end
        end
    endtask

    task automatic check_cycle();
        logic     rdy;
        word_t    val;
        rob_tag_t tag;
        exp_stall  = held_valid && (rs_full[held_fu] || ref_count == ROB_SIZE);
        exp_alloc  = held_valid && !exp_stall;
        exp_load   = '0;
        if (exp_alloc) begin
            exp_load[held_fu] = 1'b1;
        end
        exp_commit = ref_busy[ref_head] && ref_done[ref_head];
        check_value("stall", stall, exp_stall);
        check_value("rs_load", rs_load, exp_load);
        check_value("commit_valid", commit_valid, exp_commit);
        if (exp_commit) begin
            check_value("commit_tag", commit_tag, ref_head);
            check_value("commit_reg", commit_reg, ref_dest[ref_head]);
            check_value("commit_data", commit_data, ref_value[ref_head]);
            check_value("commit_npc", commit_npc, ref_npc[ref_head]);
        end
        if (held_valid) begin
            check_value("rs_func", rs_func, held_func);
            check_value("rs_tag_dest", rs_tag_dest, ref_tail);
            check_value("rs_imm", rs_imm, (held_fu == FU_BTU) ? held_imm : '0);
            check_value("rs_pc", rs_pc, (held_fu == FU_BTU) ? held_pc : '0);
            expect_operand(held_pc_valid && held_fu != FU_BTU, held_pc, held_src1,
                           rdy, val, tag);
            check_value("rs_ready_src1", rs_ready_src1, rdy);
            check_value("rs_value_src1", rs_value_src1, val);
            check_value("rs_tag_src1", rs_tag_src1, tag);
            expect_operand(held_imm_valid && held_fu != FU_BTU, held_imm, held_src2,
                           rdy, val, tag);
            check_value("rs_ready_src2", rs_ready_src2, rdy);
            check_value("rs_value_src2", rs_value_src2, val);
            check_value("rs_tag_src2", rs_tag_src2, tag);
        end
    endtask

    // model side of one rising edge in the same order as the hardware
    task automatic update_model();
        reg_addr_t d;
        if (exp_stall) begin
            n_stalls++;
        end
        if (exp_commit) begin
            d = ref_dest[ref_head];
            if (d != '0) begin
                ref_regs[d] = ref_value[ref_head];
            end
            if (ref_map_valid[d] && ref_map_tag[d] == ref_head) begin
                ref_map_valid[d] = 1'b0;
            end else if (ref_map_valid[d]) begin
                n_kept_renames++;
            end
            ref_busy[ref_head] = 1'b0;
            ref_done[ref_head] = 1'b0;
            ref_head++;
            ref_count--;
            n_commits++;
        end
        if (exp_alloc) begin
            if (held_dest != '0) begin
                ref_map_valid[held_dest] = 1'b1;
                ref_map_tag[held_dest]   = ref_tail;
            end
            ref_busy[ref_tail] = 1'b1;
            ref_done[ref_tail] = 1'b0;
            ref_dest[ref_tail] = held_dest;
            ref_npc[ref_tail]  = held_pc + 32'd4;
            ref_tail++;
            ref_count++;
            n_dispatched++;
        end
        if (cdb_valid) begin
            ref_done[cdb_tag]  = 1'b1;
            ref_value[cdb_tag] = cdb_data;
        end
        if (!exp_stall) begin
            held_valid     = inst_valid;
            held_fu        = inst_fu;
            held_func      = inst_func;
            held_dest      = inst_dest;
            held_src1      = inst_src1;
            held_src2      = inst_src2;
            held_imm       = inst_imm;
            held_imm_valid = inst_imm_valid;
            held_pc        = inst_pc;
            held_pc_valid  = inst_pc_valid;
        end
    endtask

    task automatic drive_inputs(input logic new_inst);
        rob_tag_t pending [$];
        for (int i = 0; i < RS_NUM; i++) begin
            rs_full[i] = ($urandom_range(3) == 0);
        end
        // fields stay put while the dispatcher holds the previous one
        if (new_inst) begin
            inst_valid     = ($urandom_range(9) < 8);
            inst_fu        = fu_t'($urandom_range(3));
            inst_func      = func_t'($urandom_range(15));
            // few registers so renames collide often
            inst_dest      = reg_addr_t'($urandom_range(7));
            inst_src1      = reg_addr_t'($urandom_range(7));
            inst_src2      = reg_addr_t'($urandom_range(7));
            inst_imm       = $urandom;
            inst_imm_valid = $urandom_range(1);
            inst_pc        = $urandom & 32'hffff_fffc;
            inst_pc_valid  = ($urandom_range(3) == 0);
        end
        for (int t = 0; t < ROB_SIZE; t++) begin
            if (ref_busy[t] && !ref_done[t]) begin
                pending.push_back(rob_tag_t'(t));
            end
        end
        cdb_valid = 1'b0;
        cdb_tag   = '0;
        cdb_data  = '0;
        if (pending.size() > 0 && $urandom_range(9) < 7) begin
            cdb_valid = 1'b1;
            cdb_tag   = pending[$urandom_range(pending.size() - 1)];
            cdb_data  = $urandom;
        end
    endtask

    initial begin
        #(WATCHDOG_TIME);
        stop_with_error("watchdog expired before all instructions were dispatched");
    end

    initial begin
        void'($urandom(23));
        reset          = 1'b1;
        inst_valid     = 1'b0;
        inst_fu        = FU_ALU;
        inst_func      = '0;
        inst_dest      = '0;
        inst_src1      = '0;
        inst_src2      = '0;
        inst_imm       = '0;
        inst_imm_valid = 1'b0;
        inst_pc        = '0;
        inst_pc_valid  = 1'b0;
        rs_full        = '0;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        cdb_data       = '0;
        for (int i = 0; i < REG_NUM; i++) begin
            ref_map_valid[i] = 1'b0;
            ref_map_tag[i]   = '0;
            ref_regs[i]      = '0;
        end
        for (int t = 0; t < ROB_SIZE; t++) begin
            ref_busy[t] = 1'b0;
            ref_done[t] = 1'b0;
        end
        ref_head   = '0;
        ref_tail   = '0;
        ref_count  = 0;
        held_valid = 1'b0;
        exp_stall  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        drive_inputs(1'b1);
        while (n_dispatched < NUM_INST) begin
            @(negedge clk);
            check_cycle();
            @(posedge clk);
            update_model();
            #1;
            drive_inputs(!exp_stall);
        end
        $display("dispatched %0d, committed %0d, stall cycles %0d, kept renames %0d",
                 n_dispatched, n_commits, n_stalls, n_kept_renames);
        // back-pressure and a surviving newer rename must both have been exercised
        assert (n_stalls > 0)
        else stop_with_error("no stall cycle occurred during the run");
        assert (n_kept_renames > 0)
        else stop_with_error("no newer rename survived an older commit during the run");
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
